//--- hpet_defs.svh
// HPET timer count, bus widths, register map and ID values
`ifndef HPET_DEFS_SVH
`define HPET_DEFS_SVH

// Timer count, fixed for the whole design
`define HPET_NUM_TIMERS     2

// APB bus widths
`define HPET_ADDR_W         12
`define HPET_DATA_W         32

// ID register fields
`define HPET_VENDOR_ID      8'h01
`define HPET_REVISION_ID    8'h01

// Global register offsets
`define HPET_REG_ID         12'h000
`define HPET_REG_CONFIG     12'h004
`define HPET_REG_STATUS     12'h008
`define HPET_REG_COUNTER    12'h010

// Timer blocks, 32 bytes each from 0x100
`define HPET_TIMER_BASE     12'h100
`define HPET_TIMER_STRIDE   12'h020
`define HPET_TMR_CONFIG     12'h000
`define HPET_TMR_COMP       12'h004

`endif

//--- hpet_pkg.sv
// HPET shared types for bus words, APB requests, timer control and interrupts
`include "hpet_defs.svh"

package hpet_pkg;

    // Data word for counter, comparator and register traffic
    typedef logic [`HPET_DATA_W-1:0] hpet_word_t;

    // Captured APB access
    typedef struct packed {
        logic [`HPET_ADDR_W-1:0] addr;
        logic                    write;
        hpet_word_t              wdata;
    } apb_req_t;

    // Timer CONFIG fields, bit 4 down to bit 2 live
    typedef struct packed {
        logic [24:0] rsvd_hi;
        logic [1:0]  rsvd_mode;   // Old value-set and size bits
        logic        periodic;
        logic        int_enable;
        logic        enable;
        logic [1:0]  rsvd_lo;
    } timer_cfg_t;

    // Same CONFIG word, raw for the bus, fields for the timer
    typedef union packed {
        hpet_word_t raw;
        timer_cfg_t fields;
    } timer_cfg_u;

    // Per-timer control from the register slave
    typedef struct packed {
        timer_cfg_u cfg;
        logic       comp_write;
        hpet_word_t comp_wdata;
    } timer_ctrl_t;

    // One bit per timer
    typedef logic [`HPET_NUM_TIMERS-1:0] irq_vec_t;

endpackage

//--- hpet_apb_regs.sv
// HPET APB4 register slave with address decode, global registers and read mux
`timescale 1ns/1ps
`include "hpet_defs.svh"

module hpet_apb_regs
    import hpet_pkg::*;
(
    input  logic        pclk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  apb_req_t    req,
    output logic        pready,
    output logic        pslverr,
    output hpet_word_t  prdata,
    output logic        hpet_enable,
    output logic        counter_load,
    output hpet_word_t  counter_wdata,
    input  hpet_word_t  count,
    output timer_ctrl_t timer_ctrl [`HPET_NUM_TIMERS],
    input  hpet_word_t  timer_comp [`HPET_NUM_TIMERS],
    input  irq_vec_t    status,
    output irq_vec_t    status_clear
);

    // First address past the last timer block
    localparam logic [`HPET_ADDR_W-1:0] ERR_BASE =
        `HPET_ADDR_W'(`HPET_TIMER_BASE + `HPET_NUM_TIMERS * `HPET_TIMER_STRIDE);

    // Vendor, revision, timers minus one, no capability bits
    localparam hpet_word_t ID_WORD = {`HPET_VENDOR_ID, `HPET_REVISION_ID, 3'b000,
                                      5'(`HPET_NUM_TIMERS - 1), 8'h00};

    logic                        access;
    logic                        addr_err;
    logic                        wr_en;
    logic [`HPET_NUM_TIMERS-1:0] tmr_cfg_hit;
    logic [`HPET_NUM_TIMERS-1:0] tmr_comp_hit;
    hpet_word_t                  hpet_cfg;
    timer_cfg_u                  tmr_cfg [`HPET_NUM_TIMERS];
    hpet_word_t                  rdata;

    // ====================
    // Decode
    // ====================
    // Access phase, no wait states
    assign access   = psel & penable;
    assign addr_err = req.addr >= ERR_BASE;
    // Errored writes change nothing
    assign wr_en    = access & req.write & ~addr_err;

    // Per-timer register hits
    for (genvar g = 0; g < `HPET_NUM_TIMERS; g++) begin : g_tmr_dec
        localparam logic [`HPET_ADDR_W-1:0] BLK_BASE =
            `HPET_ADDR_W'(`HPET_TIMER_BASE + g * `HPET_TIMER_STRIDE);
        assign tmr_cfg_hit[g]  = req.addr == BLK_BASE + `HPET_TMR_CONFIG;
        assign tmr_comp_hit[g] = req.addr == BLK_BASE + `HPET_TMR_COMP;
    end

    // ====================
    // Registers
    // ====================
    // Global CONFIG and timer CONFIG words, stored whole
    always_ff @(posedge pclk) begin
        if (reset) begin
            hpet_cfg <= '0;
            for (int i = 0; i < `HPET_NUM_TIMERS; i++) begin
                tmr_cfg[i].raw <= '0;
            end
        end else if (wr_en) begin
            if (req.addr == `HPET_REG_CONFIG) begin
                hpet_cfg <= req.wdata;
            end
            for (int i = 0; i < `HPET_NUM_TIMERS; i++) begin
                if (tmr_cfg_hit[i]) begin
                    tmr_cfg[i].raw <= req.wdata;
                end
            end
        end
    end

    // Counter enable and load strobe
    assign hpet_enable   = hpet_cfg[0];
    assign counter_load  = wr_en && (req.addr == `HPET_REG_COUNTER);
    assign counter_wdata = req.wdata;

    // W1C pulse toward the status block
    assign status_clear = (wr_en && (req.addr == `HPET_REG_STATUS)) ?
                          req.wdata[`HPET_NUM_TIMERS-1:0] : '0;

    // Timer controls, COMP write is a single-cycle pulse
    always_comb begin
        for (int i = 0; i < `HPET_NUM_TIMERS; i++) begin
            timer_ctrl[i].cfg        = tmr_cfg[i];
            timer_ctrl[i].comp_write = wr_en & tmr_comp_hit[i];
            timer_ctrl[i].comp_wdata = req.wdata;
        end
    end

    // ====================
    // Readback
    // ====================
    // Gaps read zero
    always_comb begin
        rdata = '0;
        case (req.addr)
            `HPET_REG_ID:      rdata = ID_WORD;
            `HPET_REG_CONFIG:  rdata = hpet_cfg;
            `HPET_REG_STATUS:  rdata[`HPET_NUM_TIMERS-1:0] = status;
            `HPET_REG_COUNTER: rdata = count;
            default:           rdata = '0;
        endcase
        for (int i = 0; i < `HPET_NUM_TIMERS; i++) begin
            if (tmr_cfg_hit[i]) begin
                rdata = tmr_cfg[i].raw;
            end
            if (tmr_comp_hit[i]) begin
                rdata = timer_comp[i];
            end
        end
    end

    assign pready  = access;
    assign pslverr = access & addr_err;
    assign prdata  = (access && !req.write) ? rdata : '0;

endmodule

//--- hpet_main_counter.sv
// HPET main counter, counts up each cycle when enabled, software loadable
`timescale 1ns/1ps

module hpet_main_counter
    import hpet_pkg::*;
(
    input  logic       pclk,
    input  logic       reset,
    input  logic       enable,
    input  logic       load,
    input  hpet_word_t load_value,
    output hpet_word_t count
);

    // ====================
    // Counter
    // ====================
    // Load beats increment
    // Wraps at 2^32
    always_ff @(posedge pclk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- hpet_timer.sv
// HPET comparator timer with one-shot and periodic modes
`timescale 1ns/1ps

module hpet_timer
    import hpet_pkg::*;
(
    input  logic        pclk,
    input  logic        reset,
    input  timer_ctrl_t ctrl,
    input  hpet_word_t  count,
    output hpet_word_t  comparator,
    output logic        fire
);

    hpet_word_t period;
    logic       armed;
    logic       enable;
    logic       periodic;
    logic       hit;

    // Field view of the CONFIG union
    assign enable   = ctrl.cfg.fields.enable;
    assign periodic = ctrl.cfg.fields.periodic;

    // Compare against the live count
    assign hit = armed & enable & (count >= comparator);

    // ====================
    // Compare state
    // ====================
    always_ff @(posedge pclk) begin
        if (reset) begin
            comparator <= '0;
            armed      <= 1'b0;
            fire       <= 1'b0;
        end else if (ctrl.comp_write) begin
            // Software write re-arms
            comparator <= ctrl.comp_wdata;
            armed      <= 1'b1;
            fire       <= 1'b0;
        end else begin
            fire <= hit;
            if (hit) begin
                if (periodic) begin
                    // Next deadline, no software needed
                    comparator <= comparator + period;
                end else begin
                    // One-shot done until next COMP write
                    armed <= 1'b0;
                end
            end
        end
    end

    // Period latched with the comparator write
    always_ff @(posedge pclk) begin
        if (ctrl.comp_write) begin
            period <= ctrl.comp_wdata;
        end
    end

endmodule

//--- hpet_irq_status.sv
// HPET interrupt status, sticky W1C pending bits and interrupt gating
`timescale 1ns/1ps

module hpet_irq_status
    import hpet_pkg::*;
(
    input  logic     pclk,
    input  logic     reset,
    input  irq_vec_t fire,
    input  irq_vec_t status_clear,
    input  irq_vec_t int_enable,
    output irq_vec_t status,
    output irq_vec_t irq
);

    irq_vec_t status_next;

    // ====================
    // Pending bits
    // ====================
    // Clear first, then set, so a fire in the same cycle wins
    always_comb begin
        status_next = (status & ~status_clear) | fire;
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            status <= '0;
        end else begin
            status <= status_next;
        end
    end

    // ====================
    // Output gating
    // ====================
    // Status still latches with interrupts masked
    assign irq = status & int_enable;

endmodule

//--- hpet_top.sv
// HPET top level, APB slave, main counter, comparator timers and interrupt status
`timescale 1ns/1ps
`include "hpet_defs.svh"

module hpet_top
    import hpet_pkg::*;
(
    input  logic                    pclk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`HPET_ADDR_W-1:0] paddr,
    input  hpet_word_t              pwdata,
    output logic                    pready,
    output logic                    pslverr,
    output hpet_word_t              prdata,
    output irq_vec_t                timer_irq
);

    apb_req_t    req;
    logic        hpet_enable;
    logic        counter_load;
    hpet_word_t  counter_wdata;
    hpet_word_t  count;
    timer_ctrl_t timer_ctrl [`HPET_NUM_TIMERS];
    hpet_word_t  timer_comp [`HPET_NUM_TIMERS];
    irq_vec_t    fire;
    irq_vec_t    int_enable;
    irq_vec_t    status;
    irq_vec_t    status_clear;

    // Bundle the APB request
    assign req = '{addr: paddr, write: pwrite, wdata: pwdata};

    // ====================
    // Register slave
    // ====================
    hpet_apb_regs u_regs (
        .pclk          (pclk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .req           (req),
        .pready        (pready),
        .pslverr       (pslverr),
        .prdata        (prdata),
        .hpet_enable   (hpet_enable),
        .counter_load  (counter_load),
        .counter_wdata (counter_wdata),
        .count         (count),
        .timer_ctrl    (timer_ctrl),
        .timer_comp    (timer_comp),
        .status        (status),
        .status_clear  (status_clear)
    );

    hpet_main_counter u_counter (
        .pclk       (pclk),
        .reset      (reset),
        .enable     (hpet_enable),
        .load       (counter_load),
        .load_value (counter_wdata),
        .count      (count)
    );

    // ====================
    // Timers
    // ====================
    for (genvar g = 0; g < `HPET_NUM_TIMERS; g++) begin : g_timer
        // Interrupt enable pulled out of each CONFIG word
        assign int_enable[g] = timer_ctrl[g].cfg.fields.int_enable;

        hpet_timer u_timer (
            .pclk       (pclk),
            .reset      (reset),
            .ctrl       (timer_ctrl[g]),
            .count      (count),
            .comparator (timer_comp[g]),
            .fire       (fire[g])
        );
    end

    hpet_irq_status u_status (
        .pclk         (pclk),
        .reset        (reset),
        .fire         (fire),
        .status_clear (status_clear),
        .int_enable   (int_enable),
        .status       (status),
        .irq          (timer_irq)
    );

endmodule

//--- tb_hpet.sv
// HPET testbench, register table, one-shot, periodic and masked interrupt checks
`timescale 1ns/1ps
`include "hpet_defs.svh"

module tb_hpet
    import hpet_pkg::*;
();

    // Timer block register addresses
    localparam logic [11:0] T0_CFG  = `HPET_TIMER_BASE + `HPET_TMR_CONFIG;
    localparam logic [11:0] T0_COMP = `HPET_TIMER_BASE + `HPET_TMR_COMP;
    localparam logic [11:0] T1_CFG  = `HPET_TIMER_BASE + `HPET_TIMER_STRIDE + `HPET_TMR_CONFIG;
    localparam logic [11:0] T1_COMP = `HPET_TIMER_BASE + `HPET_TIMER_STRIDE + `HPET_TMR_COMP;

    // One table row, either a write or a read
    typedef struct {
        string       name;
        logic [11:0] addr;
        logic        wr;
        hpet_word_t  data;
        hpet_word_t  exp;
        logic        exp_err;
    } row_t;

    logic        pclk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    hpet_word_t  pwdata;
    logic        pready;
    logic        pslverr;
    hpet_word_t  prdata;
    irq_vec_t    timer_irq;

    row_t        rows [$];
    integer      seed = 38;

    hpet_top dut0 (
        .pclk      (pclk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .prdata    (prdata),
        .timer_irq (timer_irq)
    );

    // 4 ns period
    always #2 pclk = ~pclk;

    // ====================
    // Checks
    // ====================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input hpet_word_t exp, input hpet_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    // ====================
    // APB master
    // ====================
    // Setup cycle, access cycle, then idle
    task automatic apb_access(input logic [11:0] addr, input logic wr, input hpet_word_t wdata,
                              output hpet_word_t rdata, output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        // Mid low phase, away from any edge
        #1;
        check_err("pready", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input hpet_word_t data, output logic err);
        hpet_word_t unused_rd;
        apb_access(addr, 1'b1, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output hpet_word_t data, output logic err);
        apb_access(addr, 1'b0, '0, data, err);
    endtask

    // Write expected to succeed
    task automatic reg_write(input logic [11:0] addr, input hpet_word_t data);
        logic err;
        apb_write(addr, data, err);
        check_err($sformatf("pslverr write %h", addr), 1'b0, err);
    endtask

    task automatic add_row(input string name, input logic [11:0] addr, input logic wr,
                           input hpet_word_t data, input hpet_word_t exp, input logic exp_err);
        row_t r;
        r.name    = name;
        r.addr    = addr;
        r.wr      = wr;
        r.data    = data;
        r.exp     = exp;
        r.exp_err = exp_err;
        rows.push_back(r);
    endtask

    // Comparator or period in 20..60
    function automatic hpet_word_t rand_comp();
        hpet_word_t r;
        r = $random(seed);
        return 32'd20 + (r % 32'd41);
    endfunction

    // Poll STATUS over the bus until the bit sets
    task automatic wait_status(input int idx);
        hpet_word_t st;
        logic       err;
        int         cycles;
        bit         seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 500) begin
            apb_read(`HPET_REG_STATUS, st, err);
            seen   = st[idx];
            cycles = cycles + 3;
        end
        if (!seen) begin
            abort_run($sformatf("Timeout, timer %0d never fired within 500 cycles", idx));
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        hpet_word_t rd;
        hpet_word_t comp;
        hpet_word_t period;
        hpet_word_t prev;
        logic       err;

        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge pclk);
        @(negedge pclk);
        reset = 1'b0;

        // Idle outputs out of reset
        check_irq("reset timer_irq", '0, timer_irq);
        check_word("reset prdata", '0, prdata);
        check_err("reset pslverr", 1'b0, pslverr);
        check_err("reset pready", 1'b0, pready);

        // ID is vendor 1, revision 1, one as timers minus one
        add_row("id",          `HPET_REG_ID, 1'b0, '0, 32'h0101_0100, 1'b0);
        add_row("gap_00c",     12'h00C, 1'b0, '0, '0, 1'b0);
        add_row("gap_10c",     12'h10C, 1'b0, '0, '0, 1'b0);
        add_row("err_rd_140",  12'h140, 1'b0, '0, '0, 1'b1);
        add_row("err_rd_ffc",  12'hFFC, 1'b0, '0, '0, 1'b1);
        add_row("err_wr_140",  12'h140, 1'b1, 32'hFFFF_FFFF, '0, 1'b1);
        // Global enable stays off here
        add_row("cfg_wr",      `HPET_REG_CONFIG, 1'b1, 32'h1234_5670, '0, 1'b0);
        add_row("cfg_rd",      `HPET_REG_CONFIG, 1'b0, '0, 32'h1234_5670, 1'b0);
        add_row("t0_cfg_wr",   T0_CFG, 1'b1, 32'hFFFF_FFE3, '0, 1'b0);
        add_row("t0_cfg_rd",   T0_CFG, 1'b0, '0, 32'hFFFF_FFE3, 1'b0);
        add_row("t1_cfg_wr",   T1_CFG, 1'b1, 32'h8000_0001, '0, 1'b0);
        add_row("t1_cfg_rd",   T1_CFG, 1'b0, '0, 32'h8000_0001, 1'b0);
        add_row("t0_comp_wr",  T0_COMP, 1'b1, 32'hDEAD_BEEF, '0, 1'b0);
        add_row("t0_comp_rd",  T0_COMP, 1'b0, '0, 32'hDEAD_BEEF, 1'b0);
        add_row("t1_comp_wr",  T1_COMP, 1'b1, 32'h0000_1234, '0, 1'b0);
        add_row("t1_comp_rd",  T1_COMP, 1'b0, '0, 32'h0000_1234, 1'b0);
        add_row("cnt_ld",      `HPET_REG_COUNTER, 1'b1, 32'h0000_ABCD, '0, 1'b0);
        add_row("cnt_rd",      `HPET_REG_COUNTER, 1'b0, '0, 32'h0000_ABCD, 1'b0);

        foreach (rows[i]) begin
            if (rows[i].wr) begin
                apb_write(rows[i].addr, rows[i].data, err);
            end else begin
                apb_read(rows[i].addr, rd, err);
                check_word(rows[i].name, rows[i].exp, rd);
            end
            check_err({rows[i].name, " pslverr"}, rows[i].exp_err, err);
        end

        // Disabled counter holds its loaded value
        repeat (20) @(negedge pclk);
        apb_read(`HPET_REG_COUNTER, rd, err);
        check_word("cnt_hold", 32'h0000_ABCD, rd);
        reg_write(T0_CFG, '0);
        reg_write(T1_CFG, '0);

        // ====================
        // One-shot, timer 0
        // ====================
        comp = rand_comp();
        reg_write(`HPET_REG_COUNTER, '0);
        reg_write(T0_COMP, comp);
        // Timer enable and interrupt enable
        reg_write(T0_CFG, 32'h0000_000C);
        reg_write(`HPET_REG_CONFIG, 32'h1);
        wait_status(0);
        check_irq("oneshot irq", 2'b01, timer_irq);
        apb_read(`HPET_REG_COUNTER, rd, err);
        if (rd < comp) begin
            abort_run($sformatf("Counter %0d below comparator %0d after fire", rd, comp));
        end
        reg_write(`HPET_REG_STATUS, 32'h1);
        apb_read(`HPET_REG_STATUS, rd, err);
        check_word("oneshot status clear", '0, rd);
        // Disarmed, so nothing comes back
        repeat (200) begin
            @(negedge pclk);
            check_irq("oneshot quiet irq", '0, timer_irq);
        end
        apb_read(`HPET_REG_STATUS, rd, err);
        check_word("oneshot quiet status", '0, rd);

        // ====================
        // Periodic, timer 1
        // ====================
        period = rand_comp();
        reg_write(`HPET_REG_CONFIG, '0);
        reg_write(T0_CFG, '0);
        reg_write(`HPET_REG_COUNTER, '0);
        reg_write(T1_COMP, period);
        // Periodic, interrupt enable, timer enable
        reg_write(T1_CFG, 32'h0000_001C);
        reg_write(`HPET_REG_CONFIG, 32'h1);
        prev = period;
        for (int k = 0; k < 3; k++) begin
            wait_status(1);
            check_irq($sformatf("periodic irq %0d", k), 2'b10, timer_irq);
            apb_read(T1_COMP, rd, err);
            check_word($sformatf("periodic comp %0d", k), prev + period, rd);
            prev = prev + period;
            reg_write(`HPET_REG_STATUS, 32'h2);
        end

        // ====================
        // Masked interrupt, timer 0
        // ====================
        reg_write(`HPET_REG_CONFIG, '0);
        reg_write(T1_CFG, '0);
        reg_write(`HPET_REG_STATUS, 32'h3);
        reg_write(`HPET_REG_COUNTER, '0);
        comp = rand_comp();
        reg_write(T0_COMP, comp);
        // Timer enable only
        reg_write(T0_CFG, 32'h0000_0004);
        reg_write(`HPET_REG_CONFIG, 32'h1);
        wait_status(0);
        check_irq("masked irq", '0, timer_irq);
        reg_write(`HPET_REG_STATUS, 32'h1);
        // W1C on bits already clear
        reg_write(`HPET_REG_STATUS, 32'h3);
        apb_read(`HPET_REG_STATUS, rd, err);
        check_word("w1c idle status", '0, rd);
        check_irq("w1c idle irq", '0, timer_irq);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
hpet_pkg.sv
hpet_apb_regs.sv
hpet_main_counter.sv
hpet_timer.sv
hpet_irq_status.sv
hpet_top.sv
tb_hpet.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_hpet
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
